//--- dv/buf_rd_checker.sv
`include "buf_rd_settings.svh"
`default_nettype none

module buf_rd_checker (
	 input  logic                  clk
	,input  logic                  rstn
	,input  logic                  s_rvalid
	,input  logic                  s_rready
	,input  buf_rd_pkg::buf_addr_t b_raddr
	,input  buf_rd_pkg::seg_idx_t  freed_pointer
	,input  logic                  freed_pointer_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	import buf_rd_pkg::*;

	// expected words, in order, with a flag on each segment's last word
	buf_addr_t exp_addr [$];
	logic      exp_last [$];
	seg_idx_t  exp_freed [$];
	// segments whose last word has been taken, oldest first
	seg_idx_t  done_segs [$];

	string     test_name = "reset";
	int        word_errs = 0;
	int        freed_errs = 0;
	int        freed_seen = 0;

	task automatic set_test(input string name);
		test_name = name;
	endtask

	task automatic add_word(input buf_addr_t addr, input logic last);
		exp_addr.push_back(addr);
		exp_last.push_back(last);
	endtask

	task automatic add_freed(input seg_idx_t seg);
		exp_freed.push_back(seg);
	endtask

	// words and releases still outstanding
	function automatic int pending();
		return exp_addr.size() + exp_freed.size();
	endfunction

	always @(posedge clk) begin : monitor
		buf_addr_t a;
		logic      l;
		seg_idx_t  s;
		// a word is taken on valid and ready
		if (rstn && s_rvalid && s_rready) begin
			if (exp_addr.size() == 0) begin
				word_errs++;
				$display("%s: word at address %h taken while none was expected",
					test_name, b_raddr);
			end else begin
				a = exp_addr.pop_front();
				l = exp_last.pop_front();
				if (a !== b_raddr) begin
					word_errs++;
					$display("Fail %s word expected %h actual %h", test_name, a, b_raddr);
				end
				// segment counts as done once its last word is out
				if (l) begin
					done_segs.push_back(seg_idx_t'(b_raddr >> `SEG_OFF_W));
				end
			end
		end
		if (rstn && freed_pointer_valid) begin
			freed_seen++;
			if (done_segs.size() == 0) begin
				freed_errs++;
				$display("%s: segment %h released before its last word was taken",
					test_name, freed_pointer);
			end else begin
				s = done_segs.pop_front();
				if (s !== freed_pointer) begin
					freed_errs++;
					$display("Fail %s completion order expected %h actual %h",
						test_name, s, freed_pointer);
				end
			end
			if (exp_freed.size() == 0) begin
				freed_errs++;
				$display("%s: release of segment %h was not expected",
					test_name, freed_pointer);
			end else begin
				s = exp_freed.pop_front();
				if (s !== freed_pointer) begin
					freed_errs++;
					$display("Fail %s freed expected %h actual %h", test_name, s, freed_pointer);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/buf_rd_sva.sv
`include "buf_rd_settings.svh"
`default_nettype none

module buf_rd_sva (
	 input  logic                   clk
	,input  logic                   rstn
	,input  logic                   used_pointer_valid
	,input  buf_rd_pkg::flow_id_t   used_pointer_flow
	,input  buf_rd_pkg::flow_vec_t  fifo_pop
	,input  buf_rd_pkg::flow_vec_t  flow_empty
	,input  logic                   s_rready
	,input  logic                   s_rvalid
	,input  buf_rd_pkg::buf_addr_t  b_raddr
);

	timeunit 1ns;
	timeprecision 100ps;

	import buf_rd_pkg::*;

	// occupancy of each queue as seen from the write bus and pops
	int occ [`NUM_FLOWS];
	// count of failed assertions
	int assert_errs = 0;

	always @(posedge clk) begin : occ_track
		logic wr_hit;
		for (int i = 0; i < `NUM_FLOWS; i++) begin
			wr_hit = used_pointer_valid && (int'(used_pointer_flow) == i);
			if (!rstn) begin
				occ[i] <= 0;
			end else if (wr_hit && !fifo_pop[i]) begin
				occ[i] <= occ[i] + 1;
			end else if (!wr_hit && fifo_pop[i]) begin
				occ[i] <= occ[i] - 1;
			end
		end
	end

	a_pop_not_empty: assert property (@(posedge clk) disable iff (!rstn)
		(fifo_pop & flow_empty) == '0)
		else begin
			$error("pop of an empty flow queue");
			assert_errs++;
		end

	a_no_full_write: assert property (@(posedge clk) disable iff (!rstn)
		used_pointer_valid |-> occ[used_pointer_flow] != `FIFO_DEPTH)
		else begin
			$error("write to a full flow queue");
			assert_errs++;
		end

	a_pop_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0(fifo_pop))
		else begin
			$error("more than one queue popped at once");
			assert_errs++;
		end

	// stalled word must hold until taken
	a_hold_stalled: assert property (@(posedge clk) disable iff (!rstn)
		(s_rvalid && !s_rready) |=> (s_rvalid && $stable(b_raddr)))
		else begin
			$error("read word changed while stalled");
			assert_errs++;
		end

endmodule

bind buf_rd_top buf_rd_sva i_buf_rd_sva (
	 .clk                (clk)
	,.rstn               (rstn)
	,.used_pointer_valid (used_pointer_valid)
	,.used_pointer_flow  (used_pointer_flow)
	,.fifo_pop           (fifo_pop)
	,.flow_empty         (flow_empty)
	,.s_rready           (s_rready)
	,.s_rvalid           (s_rvalid)
	,.b_raddr            (b_raddr)
);

`default_nettype wire

//--- dv/buf_rd_tb.sv
`include "buf_rd_settings.svh"
`default_nettype none

module buf_rd_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import buf_rd_pkg::*;

	localparam int DRAIN_LIMIT = 2000;
	localparam int FREED_LIMIT = 200;

	logic       clk;
	logic       rstn;
	ptr_entry_t used_pointer;
	logic       used_pointer_valid;
	flow_id_t   used_pointer_flow;
	logic       s_rready;
	logic       s_rvalid;
	buf_addr_t  b_raddr;
	seg_idx_t   freed_pointer;
	logic       freed_pointer_valid;

	logic [15:0] lfsr_state = 16'd41;
	int          errs = 0;
	bit          abort = 0;
	int          rr_model = 0;
	int          next_slot [`NUM_FLOWS];
	// per-flow descriptors the reference has not yet played out
	ptr_entry_t  desc_q [`NUM_FLOWS][$];
	// writes still to be driven onto the bus
	int          wr_flow_q [$];
	ptr_entry_t  wr_desc_q [$];

	buf_rd_top i_buf_rd_top (
		 .clk                 (clk)
		,.rstn                (rstn)
		,.used_pointer        (used_pointer)
		,.used_pointer_valid  (used_pointer_valid)
		,.used_pointer_flow   (used_pointer_flow)
		,.s_rready            (s_rready)
		,.s_rvalid            (s_rvalid)
		,.b_raddr             (b_raddr)
		,.freed_pointer       (freed_pointer)
		,.freed_pointer_valid (freed_pointer_valid)
	);

	buf_rd_checker i_buf_rd_checker (
		 .clk                 (clk)
		,.rstn                (rstn)
		,.s_rvalid            (s_rvalid)
		,.s_rready            (s_rready)
		,.b_raddr             (b_raddr)
		,.freed_pointer       (freed_pointer)
		,.freed_pointer_valid (freed_pointer_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois lfsr with taps for x^16+x^14+x^13+x^11+1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
	endtask

	// round robin picks the first pending flow at or after rr
	function automatic int pick_flow(input int rr, input logic [`NUM_FLOWS-1:0] pend);
		int f;
		pick_flow = -1;
		for (int k = 0; k < `NUM_FLOWS; k++) begin
			f = (rr + k) % `NUM_FLOWS;
			if (pend[f] && pick_flow < 0) begin
				pick_flow = f;
			end
		end
	endfunction

	function automatic logic [`NUM_FLOWS-1:0] pending_flows();
		logic [`NUM_FLOWS-1:0] p;
		for (int f = 0; f < `NUM_FLOWS; f++) begin
			p[f] = (desc_q[f].size() != 0);
		end
		return p;
	endfunction

	// every word of one segment, then its release
	task automatic expect_segment(input ptr_entry_t d);
		seg_idx_t seg;
		int       endo;
		seg  = d[`BUF_SEG_AW-1:0];
		endo = int'(d[`BUF_SEG_AW +: `SEG_OFF_W]);
		for (int o = 0; o <= endo; o++) begin
			i_buf_rd_checker.add_word({seg, seg_off_t'(o)}, o == endo);
		end
		i_buf_rd_checker.add_freed(seg);
	endtask

	// plays whole packets in round-robin order over the queued descriptors
	task automatic build_expected();
		logic [`NUM_FLOWS-1:0] pend;
		int                    f;
		ptr_entry_t            d;
		bit                    done;
		pend = pending_flows();
		while (pend != '0) begin
			f    = pick_flow(rr_model, pend);
			done = 0;
			while (!done && desc_q[f].size() != 0) begin
				d = desc_q[f].pop_front();
				expect_segment(d);
				done = d[`BUF_SEG_AW+`SEG_OFF_W];
			end
			rr_model = (f + 1) % `NUM_FLOWS;
			pend     = pending_flows();
		end
	endtask

	// flow f owns segments 4f to 4f+3
	task automatic make_packet(input int f, input int nseg);
		int         r;
		ptr_entry_t d;
		for (int s = 0; s < nseg; s++) begin
			rand_bits(`SEG_OFF_W, r);
			d = {s == nseg - 1, seg_off_t'(r), seg_idx_t'(4 * f + next_slot[f])};
			next_slot[f]++;
			desc_q[f].push_back(d);
			wr_flow_q.push_back(f);
			wr_desc_q.push_back(d);
		end
	endtask

	task automatic write_desc(input int f, input ptr_entry_t d);
		@(posedge clk);
		#2;
		used_pointer_valid = 1'b1;
		used_pointer_flow  = flow_id_t'(f);
		used_pointer       = d;
		@(posedge clk);
		#2;
		used_pointer_valid = 1'b0;
	endtask

	task automatic flush_writes();
		while (wr_flow_q.size() != 0) begin
			write_desc(wr_flow_q.pop_front(), wr_desc_q.pop_front());
		end
	endtask

	// two packets per flow and at most four segments per flow
	task automatic load_all_flows();
		int r;
		int n1;
		int n2;
		for (int f = 0; f < `NUM_FLOWS; f++) begin
			next_slot[f] = 0;
			rand_bits(2, r);
			n1 = r % 3 + 1;
			rand_bits(2, r);
			n2 = 1 + r % (4 - n1);
			make_packet(f, n1);
			make_packet(f, n2);
		end
		flush_writes();
	endtask

	task automatic wait_drained(input bit random_ready);
		int n;
		int r;
		n = 0;
		while (i_buf_rd_checker.pending() != 0 && n < DRAIN_LIMIT) begin
			@(posedge clk);
			#2;
			if (random_ready) begin
				rand_bits(2, r);
				s_rready = (r != 0);
			end else begin
				s_rready = 1'b1;
			end
			n++;
		end
		s_rready = 1'b1;
		if (i_buf_rd_checker.pending() != 0) begin
			errs++;
			abort = 1;
			$display("timeout: words or releases still outstanding after %0d cycles", n);
		end
	endtask

	task automatic wait_freed(input int target);
		int n;
		n = 0;
		while (i_buf_rd_checker.freed_seen < target && n < FREED_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (i_buf_rd_checker.freed_seen < target) begin
			errs++;
			abort = 1;
			$display("timeout: segment release never came");
		end
	endtask

	task automatic check_idle(input string name, input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
			if (s_rvalid !== 1'b0) begin
				errs++;
				$display("Fail %s s_rvalid expected 0 actual %b", name, s_rvalid);
			end
			if (freed_pointer_valid !== 1'b0) begin
				errs++;
				$display("Fail %s freed_pointer_valid expected 0 actual %b",
					name, freed_pointer_valid);
			end
		end
	endtask

	// flow 1 stalls between segments while flow 2 waits its turn
	task automatic run_packet_wait();
		int         r;
		int         f_hold;
		ptr_entry_t d_hold;
		for (int f = 0; f < `NUM_FLOWS; f++) begin
			next_slot[f] = 0;
		end
		make_packet(1, 2);
		build_expected();
		write_desc(wr_flow_q.pop_front(), wr_desc_q.pop_front());
		f_hold = wr_flow_q.pop_front();
		d_hold = wr_desc_q.pop_front();
		wait_freed(i_buf_rd_checker.freed_seen + 1);
		if (!abort) begin
			rand_bits(2, r);
			make_packet(2, r % 3 + 1);
			build_expected();
			flush_writes();
			write_desc(f_hold, d_hold);
			wait_drained(0);
		end
	endtask

	task automatic finish_run();
		int total;
		total = errs + i_buf_rd_checker.word_errs + i_buf_rd_checker.freed_errs
			+ i_buf_rd_top.i_buf_rd_sva.assert_errs;
		$display("errors: words %0d, releases %0d, assertions %0d, other %0d",
			i_buf_rd_checker.word_errs, i_buf_rd_checker.freed_errs,
			i_buf_rd_top.i_buf_rd_sva.assert_errs, errs);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	initial begin
		rstn               = 1'b0;
		used_pointer       = '0;
		used_pointer_valid = 1'b0;
		used_pointer_flow  = '0;
		s_rready           = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rstn     = 1'b1;
		s_rready = 1'b1;
		check_idle("reset_idle", 8);

		// all flows loaded behind a stalled reader
		i_buf_rd_checker.set_test("round_robin");
		s_rready = 1'b0;
		load_all_flows();
		build_expected();
		wait_drained(0);

		if (!abort) begin
			i_buf_rd_checker.set_test("back_pressure");
			s_rready = 1'b0;
			load_all_flows();
			build_expected();
			wait_drained(1);
		end

		if (!abort) begin
			i_buf_rd_checker.set_test("packet_wait");
			run_packet_wait();
		end

		if (!abort) begin
			check_idle("end_idle", 8);
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- hdl/buf_rd_pkg.sv
`include "buf_rd_settings.svh"
`default_nettype none

package buf_rd_pkg;

	// segment index into the packet buffer
	typedef logic [`BUF_SEG_AW-1:0] seg_idx_t;

	// word offset inside one segment
	typedef logic [`SEG_OFF_W-1:0] seg_off_t;

	typedef logic [`FLOWS_W-1:0] flow_id_t;

	// one bit per flow, for empty flags and pops
	typedef logic [`NUM_FLOWS-1:0] flow_vec_t;

	// descriptor layout, msb down
	// last-of-packet, end offset, segment index
	typedef logic [`BUF_SEG_AW+`SEG_OFF_W:0] ptr_entry_t;

	// read address is segment then word offset
	typedef logic [`BUF_SEG_AW+`SEG_OFF_W-1:0] buf_addr_t;

	typedef enum logic [1:0] {walk_idle, walk_busy, walk_wait} walk_state_t;

endpackage

`default_nettype wire

//--- hdl/buf_rd_settings.svh
`ifndef BUF_RD_SETTINGS_SVH
`define BUF_RD_SETTINGS_SVH

// segment index width, 16 segments
`define BUF_SEG_AW 4

// word offset inside a segment, 8 words
`define SEG_OFF_W 3

// flow id width, 4 flows
`define FLOWS_W 2
`define NUM_FLOWS (1 << `FLOWS_W)

// descriptor queue depth per flow
`define FIFO_DEPTH_W 4
`define FIFO_DEPTH (1 << `FIFO_DEPTH_W)

`endif

//--- hdl/buf_rd_top.sv
`include "buf_rd_settings.svh"
`default_nettype none

module buf_rd_top (
	 input  logic                   clk
	,input  logic                   rstn
	,input  buf_rd_pkg::ptr_entry_t used_pointer
	,input  logic                   used_pointer_valid
	,input  buf_rd_pkg::flow_id_t   used_pointer_flow
	,input  logic                   s_rready
	,output logic                   s_rvalid
	,output buf_rd_pkg::buf_addr_t  b_raddr
	,output buf_rd_pkg::seg_idx_t   freed_pointer
	,output logic                   freed_pointer_valid
);

	import buf_rd_pkg::*;

	flow_vec_t  flow_empty;
	flow_vec_t  fifo_pop;
	// head descriptor of every flow queue
	ptr_entry_t head [`NUM_FLOWS];

	logic       grant_valid;
	flow_id_t   grant_flow;
	logic       pkt_start;

	// one descriptor queue per flow on a shared write bus
	for (genvar i = 0; i < `NUM_FLOWS; i++) begin : g_flow
		flow_ptr_fifo #(
			.FLOW_ID (flow_id_t'(i))
		) i_flow_ptr_fifo (
			 .clk      (clk)
			,.rstn     (rstn)
			,.wr_valid (used_pointer_valid)
			,.wr_flow  (used_pointer_flow)
			,.wr_entry (used_pointer)
			,.pop      (fifo_pop[i])
			,.head     (head[i])
			,.empty    (flow_empty[i])
		);
	end

	// picks the flow for the next packet
	flow_rr_sel i_flow_rr_sel (
		 .clk         (clk)
		,.rstn        (rstn)
		,.flow_empty  (flow_empty)
		,.pkt_start   (pkt_start)
		,.grant_valid (grant_valid)
		,.grant_flow  (grant_flow)
	);

	seg_walker i_seg_walker (
		 .clk                 (clk)
		,.rstn                (rstn)
		,.s_rready            (s_rready)
		,.flow_empty          (flow_empty)
		,.head                (head)
		,.grant_valid         (grant_valid)
		,.grant_flow          (grant_flow)
		,.pkt_start           (pkt_start)
		,.fifo_pop            (fifo_pop)
		,.b_raddr             (b_raddr)
		,.s_rvalid            (s_rvalid)
		,.freed_pointer       (freed_pointer)
		,.freed_pointer_valid (freed_pointer_valid)
	);

endmodule

`default_nettype wire

//--- hdl/flow_ptr_fifo.sv
`include "buf_rd_settings.svh"
`default_nettype none

module flow_ptr_fifo #(
	parameter buf_rd_pkg::flow_id_t FLOW_ID = '0
)(
	 input  logic                   clk
	,input  logic                   rstn
	,input  logic                   wr_valid
	,input  buf_rd_pkg::flow_id_t   wr_flow
	,input  buf_rd_pkg::ptr_entry_t wr_entry
	,input  logic                   pop
	,output buf_rd_pkg::ptr_entry_t head
	,output logic                   empty
);

	import buf_rd_pkg::*;

	// descriptor storage, no reset needed
	ptr_entry_t mem [`FIFO_DEPTH];

	logic [`FIFO_DEPTH_W-1:0] wr_ptr;
	logic [`FIFO_DEPTH_W-1:0] rd_ptr;
	// one extra bit so a full queue is representable
	logic [`FIFO_DEPTH_W:0]   count;
	logic                     wr_en;

	// shared write bus, keep only our own flow
	assign wr_en = wr_valid && (wr_flow == FLOW_ID);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// occupancy only moves when exactly one side is active
			case ({wr_en, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// first-word-fall-through, oldest entry always on head
	assign head  = mem[rd_ptr];
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- hdl/flow_rr_sel.sv
`include "buf_rd_settings.svh"
`default_nettype none

module flow_rr_sel (
	 input  logic                  clk
	,input  logic                  rstn
	,input  buf_rd_pkg::flow_vec_t flow_empty
	,input  logic                  pkt_start
	,output logic                  grant_valid
	,output buf_rd_pkg::flow_id_t  grant_flow
);

	import buf_rd_pkg::*;

	// first flow to look at on the next search
	flow_id_t rr_next;

	// search from rr_next upward with wraparound
	// loop runs backwards so the nearest candidate wins
	always_comb begin
		flow_id_t cand;
		grant_valid = 1'b0;
		grant_flow  = rr_next;
		cand        = rr_next;
		for (int k = `NUM_FLOWS - 1; k >= 0; k--) begin
			// flow id width makes the sum wrap on its own
			cand = rr_next + flow_id_t'(k);
			if (!flow_empty[cand]) begin
				grant_valid = 1'b1;
				grant_flow  = cand;
			end
		end
	end

	// move past the flow that just started a packet
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rr_next <= '0;
		end else if (pkt_start) begin
			rr_next <= grant_flow + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/seg_walker.sv
`include "buf_rd_settings.svh"
`default_nettype none

module seg_walker (
	 input  logic                   clk
	,input  logic                   rstn
	,input  logic                   s_rready
	,input  buf_rd_pkg::flow_vec_t  flow_empty
	,input  buf_rd_pkg::ptr_entry_t head [`NUM_FLOWS]
	,input  logic                   grant_valid
	,input  buf_rd_pkg::flow_id_t   grant_flow
	,output logic                   pkt_start
	,output buf_rd_pkg::flow_vec_t  fifo_pop
	,output buf_rd_pkg::buf_addr_t  b_raddr
	,output logic                   s_rvalid
	,output buf_rd_pkg::seg_idx_t   freed_pointer
	,output logic                   freed_pointer_valid
);

	import buf_rd_pkg::*;

	walk_state_t state;
	flow_id_t    cur_flow;
	ptr_entry_t  cur_entry;
	// offset of the word currently on b_raddr
	seg_off_t    loc;
	seg_off_t    loc_next;

	// fields of the active descriptor
	logic        cur_last;
	seg_off_t    cur_end;
	seg_idx_t    cur_seg;
	logic        seg_end;

	// descriptor load, from idle or when chaining segments
	logic        load_en;
	flow_id_t    load_flow;
	ptr_entry_t  next_entry;

	assign cur_last = cur_entry[`BUF_SEG_AW+`SEG_OFF_W];
	assign cur_end  = cur_entry[`BUF_SEG_AW +: `SEG_OFF_W];
	assign cur_seg  = cur_entry[`BUF_SEG_AW-1:0];
	assign seg_end  = (loc == cur_end);
	assign loc_next = loc + 1'b1;

	// pop and start decisions, all frozen by back-pressure
	always_comb begin
		load_en   = 1'b0;
		load_flow = cur_flow;
		pkt_start = 1'b0;
		fifo_pop  = '0;
		if (s_rready) begin
			case (state)
				walk_idle: begin
					if (grant_valid) begin
						load_en   = 1'b1;
						load_flow = grant_flow;
						pkt_start = 1'b1;
					end
				end
				// next segment of the same packet, no gap
				walk_busy: load_en = seg_end && !cur_last && !flow_empty[cur_flow];
				walk_wait: load_en = !flow_empty[cur_flow];
				default:   load_en = 1'b0;
			endcase
		end
		if (load_en) begin
			fifo_pop[load_flow] = 1'b1;
		end
	end

	assign next_entry = head[load_flow];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state               <= walk_idle;
			cur_flow            <= '0;
			loc                 <= '0;
			s_rvalid            <= 1'b0;
			freed_pointer_valid <= 1'b0;
		end else begin
			// single cycle pulse
			freed_pointer_valid <= 1'b0;
			if (s_rready) begin
				// last word of the segment is taken on this edge
				if (state == walk_busy && seg_end) begin
					freed_pointer_valid <= 1'b1;
				end
				if (load_en) begin
					state    <= walk_busy;
					cur_flow <= load_flow;
					loc      <= '0;
					s_rvalid <= 1'b1;
				end else begin
					case (state)
						walk_busy: begin
							if (!seg_end) begin
								loc      <= loc_next;
								s_rvalid <= 1'b1;
							end else if (cur_last) begin
								state    <= walk_idle;
								s_rvalid <= 1'b0;
							end else begin
								// rest of the packet not queued yet
								state    <= walk_wait;
								s_rvalid <= 1'b0;
							end
						end
						walk_idle: s_rvalid <= 1'b0;
						walk_wait: s_rvalid <= 1'b0;
						default: begin
							state    <= walk_idle;
							s_rvalid <= 1'b0;
						end
					endcase
				end
			end
		end
	end

	// descriptor, address and freed segment
	always_ff @(posedge clk) begin
		if (s_rready) begin
			if (load_en) begin
				cur_entry <= next_entry;
				b_raddr   <= {next_entry[`BUF_SEG_AW-1:0], {`SEG_OFF_W{1'b0}}};
			end else if (state == walk_busy && !seg_end) begin
				b_raddr <= {cur_seg, loc_next};
			end
			if (state == walk_busy && seg_end) begin
				freed_pointer <= cur_seg;
			end
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the buffer read controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module buf_rd_tb -o buf_rd_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

sim_out="$(./obj_dir/buf_rd_sim 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

//--- tb.f
+incdir+hdl
hdl/buf_rd_pkg.sv
hdl/flow_ptr_fifo.sv
hdl/flow_rr_sel.sv
hdl/seg_walker.sv
hdl/buf_rd_top.sv
dv/buf_rd_checker.sv
dv/buf_rd_sva.sv
dv/buf_rd_tb.sv
